// ==== five_cycle_cpu.f ====
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/register_file.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/writeback_stage.sv
rtl/five_cycle_cpu.sv
test/tb_clock.sv
test/five_cycle_cpu_assertions.sv
test/five_cycle_cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the five_cycle_cpu testbench with Verilator, run it, judge from the log
set -u
cd "$(dirname "$0")" || exit 1

top=five_cycle_cpu_tb
log=sim.log

verilator --binary --timing --assert --top-module "$top" -f five_cycle_cpu.f -o "$top"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Done: no errors" "$log"; then
    exit 0
fi
exit 1

// ==== test/five_cycle_cpu_tb.sv ====
`timescale 1ns/1ps

module five_cycle_cpu_tb
    import core_pkg::*;
    import isa_pkg::*;
();
    logic      clk;
    logic      rst;
    ibus_req_t ibus_req;
    logic      ibus_req_valid;
    logic      ibus_req_ready = 1'b0;
    logic      ibus_rsp_valid = 1'b0;
    word_t     ibus_rsp_data = '0;
    dbus_req_t dbus_req;
    logic      dbus_req_valid;
    logic      dbus_req_ready = 1'b0;
    logic      dbus_rsp_valid = 1'b0;
    word_t     dbus_rsp_data = '0;
    logic      halted;

    word_t imem [256];
    word_t dmem [256];
    int    grp_of [256];   // test group of each instruction slot
    string grp_name [3] = '{"arithmetic", "load/store", "branch/jal"};
    word_t exp_addr [$];
    word_t exp_data [$];
    int    exp_grp [$];
    int    prog_len = 0;
    int    slot = 0;
    int    cur_grp = 0;
    int    n_instr = 0;
    logic  ref_done = 1'b0;
    int    n_fetch = 0;
    int    n_seen = 0;
    int    n_checks = 0;
    int    errors = 0;
    int    grp_err_base = 0;
    logic  ibus_busy = 1'b0;
    logic  [1:0] ibus_delay = '0;
    word_t ibus_addr = '0;
    logic  dbus_busy = 1'b0;
    logic  [1:0] dbus_delay = '0;
    word_t dbus_addr = '0;

    tb_clock tb_clock_i (.clk(clk), .rst(rst));

    five_cycle_cpu five_cycle_cpu_i (
        .clk(clk), .rst(rst),
        .ibus_req(ibus_req), .ibus_req_valid(ibus_req_valid), .ibus_req_ready(ibus_req_ready),
        .ibus_rsp_valid(ibus_rsp_valid), .ibus_rsp_data(ibus_rsp_data),
        .dbus_req(dbus_req), .dbus_req_valid(dbus_req_valid), .dbus_req_ready(dbus_req_ready),
        .dbus_rsp_valid(dbus_rsp_valid), .dbus_rsp_data(dbus_rsp_data),
        .halted(halted)
    );

    task automatic check(string what, word_t got, word_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("FAILED %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic word_t r_word(logic [2:0] f3, logic [6:0] f7, reg_addr_t rd,
                                     reg_addr_t rs1, reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t i_word(opcode_t opc, logic [2:0] f3, reg_addr_t rd,
                                     reg_addr_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_word(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_word(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
                                     logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t u_word(reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic word_t j_word(reg_addr_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    task automatic emit(word_t ins);
        imem[prog_len] = ins;
        grp_of[prog_len] = cur_grp;
        prog_len++;
    endtask

    task automatic emit_store(reg_addr_t rs);
        emit(s_word(rs, 5'd10, 12'(slot * 4)));   // x10 holds the store base
        slot++;
    endtask

    task automatic build_program();
        logic [2:0] r_f3 [6] = '{F3_ADD, F3_ADD, F3_AND, F3_OR, F3_XOR, F3_SLT};
        logic [6:0] r_f7 [6] = '{7'h00, FUNCT7_SUB, 7'h00, 7'h00, 7'h00, 7'h00};
        logic [2:0] i_f3 [5] = '{F3_ADD, F3_AND, F3_OR, F3_XOR, F3_SLT};
        cur_grp = 0;
        emit(u_word(5'd1, 20'($urandom())));
        emit(i_word(OPC_OP_IMM, F3_ADD, 5'd1, 5'd1, 12'($urandom())));
        emit(u_word(5'd2, 20'($urandom())));
        emit(i_word(OPC_OP_IMM, F3_ADD, 5'd2, 5'd2, 12'($urandom())));
        emit(i_word(OPC_OP_IMM, F3_ADD, 5'd10, 5'd0, 12'h100));
        foreach (r_f3[k]) begin
            emit(r_word(r_f3[k], r_f7[k], 5'd3, 5'd1, 5'd2));
            emit_store(5'd3);
        end
        emit(r_word(F3_SLT, 7'h00, 5'd3, 5'd2, 5'd1));
        emit_store(5'd3);
        foreach (i_f3[k]) begin
            emit(i_word(OPC_OP_IMM, i_f3[k], 5'd4, 5'd1, 12'($urandom())));
            emit_store(5'd4);
        end
        emit(i_word(OPC_OP_IMM, F3_SLT, 5'd4, 5'd2, 12'($urandom())));
        emit_store(5'd4);
        emit(u_word(5'd5, 20'($urandom())));
        emit_store(5'd5);
        cur_grp = 1;
        emit_store(5'd1);
        emit(i_word(OPC_LOAD, 3'b010, 5'd6, 5'd10, 12'((slot - 1) * 4)));
        emit_store(5'd6);
        emit(i_word(OPC_OP_IMM, F3_ADD, 5'd0, 5'd1, 12'd5));   // write to x0
        emit_store(5'd0);
        cur_grp = 2;
        emit(i_word(OPC_OP_IMM, F3_ADD, 5'd8, 5'd0, 12'd11));
        emit(b_word(F3_BEQ, 5'd1, 5'd1, 13'd8));   // taken
        emit(i_word(OPC_OP_IMM, F3_ADD, 5'd8, 5'd0, 12'd22));
        emit_store(5'd8);
        emit(b_word(F3_BNE, 5'd1, 5'd1, 13'd8));   // not taken
        emit(i_word(OPC_OP_IMM, F3_ADD, 5'd8, 5'd0, 12'd33));
        emit_store(5'd8);
        emit(b_word(F3_BEQ, 5'd1, 5'd2, 13'd8));
        emit(i_word(OPC_OP_IMM, F3_ADD, 5'd8, 5'd0, 12'd44));
        emit_store(5'd8);
        emit(b_word(F3_BNE, 5'd1, 5'd2, 13'd8));
        emit(i_word(OPC_OP_IMM, F3_ADD, 5'd8, 5'd0, 12'd55));
        emit_store(5'd8);
        emit(j_word(5'd7, 21'd8));
        emit(i_word(OPC_OP_IMM, F3_ADD, 5'd8, 5'd0, 12'd66));
        emit_store(5'd7);
        emit_store(5'd8);
        emit(32'h00000073);   // ecall
    endtask

    function automatic word_t alu_ref(logic [2:0] f3, logic sub, word_t a, word_t b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return a + b;
        endcase
    endfunction

    // instruction set interpreter that fills the expected store list
    function automatic int run_reference();
        word_t rf [32];
        word_t dm [256];
        word_t pc;
        word_t ins;
        word_t a;
        word_t b;
        word_t addr;
        word_t next;
        int    n;
        foreach (rf[k]) rf[k] = '0;
        dm = dmem;
        pc = '0;
        n = 0;
        while (n < 4096) begin
            ins = imem[pc[9:2]];
            n++;
            if (ins[6:0] == 7'b1110011) break;
            a = rf[ins[19:15]];
            b = rf[ins[24:20]];
            next = pc + 4;
            case (ins[6:0])
                7'b0110011: rf[ins[11:7]] = alu_ref(ins[14:12], ins[31:25] == 7'h20, a, b);
                7'b0010011: rf[ins[11:7]] = alu_ref(ins[14:12], 1'b0, a,
                                                    {{20{ins[31]}}, ins[31:20]});
                7'b0110111: rf[ins[11:7]] = {ins[31:12], 12'b0};
                7'b0000011: begin
                    addr = a + {{20{ins[31]}}, ins[31:20]};
                    rf[ins[11:7]] = dm[addr[9:2]];
                end
                7'b0100011: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    dm[addr[9:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    exp_grp.push_back(grp_of[pc[9:2]]);
                end
                7'b1100011: begin
                    if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b))
                        next = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                7'b1101111: begin
                    rf[ins[11:7]] = pc + 4;
                    next = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                default: ;
            endcase
            rf[0] = '0;
            pc = next;
        end
        return n;
    endfunction

    always @(posedge clk) begin
        ibus_rsp_valid <= 1'b0;
        ibus_req_ready <= ($urandom_range(3) != 0);
        if (!rst) begin
            ibus_busy <= 1'b0;
        end else if (ibus_busy) begin
            if (ibus_delay == 2'd0) begin
                ibus_rsp_valid <= 1'b1;
                ibus_rsp_data <= imem[ibus_addr[9:2]];
                ibus_busy <= 1'b0;
            end else begin
                ibus_delay <= ibus_delay - 2'd1;
            end
        end else if (ibus_req_valid && ibus_req_ready) begin
            ibus_busy <= 1'b1;
            ibus_addr <= ibus_req.addr;
            ibus_delay <= 2'($urandom_range(3));
            n_fetch <= n_fetch + 1;
        end
    end

    always @(posedge clk) begin
        dbus_rsp_valid <= 1'b0;
        dbus_req_ready <= ($urandom_range(3) != 0);
        if (!rst) begin
            dbus_busy <= 1'b0;
        end else if (dbus_busy) begin
            if (dbus_delay == 2'd0) begin
                dbus_rsp_valid <= 1'b1;
                dbus_rsp_data <= dmem[dbus_addr[9:2]];
                dbus_busy <= 1'b0;
            end else begin
                dbus_delay <= dbus_delay - 2'd1;
            end
        end else if (dbus_req_valid && dbus_req_ready) begin
            dbus_busy <= 1'b1;
            dbus_addr <= dbus_req.addr;
            dbus_delay <= 2'($urandom_range(3));
            if (dbus_req.write) dmem[dbus_req.addr[9:2]] <= dbus_req.wdata;
        end
    end

    // compare each accepted store with the interpreter's list
    always @(posedge clk) begin
        if (rst && dbus_req_valid && dbus_req_ready && dbus_req.write) begin
            if (n_seen >= exp_addr.size()) begin
                $display("unexpected extra store to %h at %0t ns", dbus_req.addr, $time);
                errors++;
            end else begin
                check("store address", dbus_req.addr, exp_addr[n_seen]);
                check("store data", dbus_req.wdata, exp_data[n_seen]);
                if (n_seen + 1 == exp_addr.size() || exp_grp[n_seen + 1] != exp_grp[n_seen]) begin
                    $display("test %s: %0d errors", grp_name[exp_grp[n_seen]],
                             errors - grp_err_base);
                    grp_err_base = errors;
                end
            end
            n_seen++;
        end
    end

    initial begin
        wait (ref_done);
        repeat (10 + 40 * n_instr + 40) @(posedge clk);
        $display("timeout: the core did not halt within %0d instructions' time", n_instr);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int base;
        int fetch_at_halt;
        void'($urandom(32'hb1488aee));
        for (int i = 0; i < 256; i++) begin
            imem[i] = (word_t'(i) << 7) | 32'h73;   // ecall with address bits above
            dmem[i] = 32'hd5000000 ^ (word_t'(i) * 32'h00010101) ^ 32'h3c;
            grp_of[i] = 0;
        end
        build_program();
        n_instr = run_reference();
        ref_done = 1'b1;
        wait (rst);
        while (!halted) @(posedge clk);
        fetch_at_halt = n_fetch;
        repeat (20) @(posedge clk);
        base = errors;
        check("store count", word_t'(n_seen), word_t'(exp_addr.size()));
        $display("test random stalls: %0d of %0d stores, %0d errors", n_seen,
                 exp_addr.size(), errors - base);
        base = errors;
        check("fetches before halt", word_t'(fetch_at_halt), word_t'(n_instr));
        check("fetch count", word_t'(n_fetch), word_t'(n_instr));
        $display("test halt: %0d fetches for %0d instructions, %0d errors", n_fetch,
                 n_instr, errors - base);
        $display("%0d checks, %0d errors", n_checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end
endmodule

// ==== test/five_cycle_cpu_assertions.sv ====
`timescale 1ns/1ps

module five_cycle_cpu_assertions
    import core_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input ibus_req_t ibus_req,
    input logic      ibus_req_valid,
    input logic      ibus_req_ready,
    input dbus_req_t dbus_req,
    input logic      dbus_req_valid,
    input logic      dbus_req_ready,
    input logic      halted
);
    ibus_req_stable: assert property (@(posedge clk) disable iff (!rst)
        ibus_req_valid && !ibus_req_ready |=> ibus_req_valid && $stable(ibus_req))
        else $error("ibus request dropped or changed before it was taken");

    dbus_req_stable: assert property (@(posedge clk) disable iff (!rst)
        dbus_req_valid && !dbus_req_ready |=> dbus_req_valid && $stable(dbus_req))
        else $error("dbus request dropped or changed before it was taken");

    halted_sticky: assert property (@(posedge clk) disable iff (!rst) halted |=> halted)
        else $error("halted fell after the core stopped");

    no_fetch_when_halted: assert property (@(posedge clk) disable iff (!rst)
        halted |-> !ibus_req_valid)
        else $error("instruction request issued while halted");
endmodule

bind five_cycle_cpu five_cycle_cpu_assertions five_cycle_cpu_assertions_i (
    .clk(clk), .rst(rst),
    .ibus_req(ibus_req), .ibus_req_valid(ibus_req_valid), .ibus_req_ready(ibus_req_ready),
    .dbus_req(dbus_req), .dbus_req_valid(dbus_req_valid), .dbus_req_ready(dbus_req_ready),
    .halted(halted)
);

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    initial begin
        rst = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b1;
    end
endmodule

// ==== rtl/five_cycle_cpu.sv ====
`timescale 1ns/1ps

module five_cycle_cpu
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    output ibus_req_t ibus_req,
    output logic      ibus_req_valid,
    input  logic      ibus_req_ready,
    input  logic      ibus_rsp_valid,
    input  word_t     ibus_rsp_data,
    output dbus_req_t dbus_req,
    output logic      dbus_req_valid,
    input  logic      dbus_req_ready,
    input  logic      dbus_rsp_valid,
    input  word_t     dbus_rsp_data,
    output logic      halted
);
    fetch_pkt_t f_pkt;
    logic       f_valid;
    logic       f_ready;
    exec_pkt_t  d_pkt;
    logic       d_valid;
    logic       d_ready;
    mem_pkt_t   e_pkt;
    logic       e_valid;
    logic       e_ready;
    wb_pkt_t    m_pkt;
    logic       m_valid;
    logic       m_ready;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      rs1_data;
    word_t      rs2_data;
    reg_addr_t  rd;
    word_t      rd_data;
    logic       rd_we;
    logic       pc_valid;
    word_t      next_pc;
    logic       halt;

    fetch_stage fetch_stage_i (
        .clk(clk), .rst(rst),
        .ibus_req(ibus_req), .ibus_req_valid(ibus_req_valid), .ibus_req_ready(ibus_req_ready),
        .ibus_rsp_valid(ibus_rsp_valid), .ibus_rsp_data(ibus_rsp_data),
        .pc_valid(pc_valid), .next_pc(next_pc), .halt(halt),
        .out_pkt(f_pkt), .out_valid(f_valid), .out_ready(f_ready),
        .halted(halted)
    );

    decode_stage decode_stage_i (
        .clk(clk), .rst(rst),
        .in_pkt(f_pkt), .in_valid(f_valid), .in_ready(f_ready),
        .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .out_pkt(d_pkt), .out_valid(d_valid), .out_ready(d_ready)
    );

    execute_stage execute_stage_i (
        .clk(clk), .rst(rst),
        .in_pkt(d_pkt), .in_valid(d_valid), .in_ready(d_ready),
        .out_pkt(e_pkt), .out_valid(e_valid), .out_ready(e_ready)
    );

    memory_stage memory_stage_i (
        .clk(clk), .rst(rst),
        .in_pkt(e_pkt), .in_valid(e_valid), .in_ready(e_ready),
        .dbus_req(dbus_req), .dbus_req_valid(dbus_req_valid), .dbus_req_ready(dbus_req_ready),
        .dbus_rsp_valid(dbus_rsp_valid), .dbus_rsp_data(dbus_rsp_data),
        .out_pkt(m_pkt), .out_valid(m_valid), .out_ready(m_ready)
    );

    writeback_stage writeback_stage_i (
        .in_pkt(m_pkt), .in_valid(m_valid), .in_ready(m_ready),
        .rd(rd), .rd_data(rd_data), .rd_we(rd_we),
        .pc_valid(pc_valid), .next_pc(next_pc), .halt(halt)
    );

    register_file register_file_i (
        .clk(clk), .rst(rst),
        .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rd(rd), .rd_data(rd_data), .rd_we(rd_we)
    );
endmodule

// ==== rtl/writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage
    import core_pkg::*;
    import isa_pkg::*;
(
    input  wb_pkt_t   in_pkt,
    input  logic      in_valid,
    output logic      in_ready,
    output reg_addr_t rd,
    output word_t     rd_data,
    output logic      rd_we,
    output logic      pc_valid,
    output word_t     next_pc,
    output logic      halt
);
    assign in_ready = 1'b1;   // never stalls

    assign rd = in_pkt.rd;
    assign rd_data = in_pkt.result;
    assign rd_we = in_valid && in_pkt.rd_we && (in_pkt.rd != X0);

    // fetch is idle here, so the pc goes back without a handshake
    assign pc_valid = in_valid;
    assign next_pc = in_pkt.next_pc;
    assign halt = in_valid && in_pkt.is_halt;
endmodule

// ==== rtl/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  mem_pkt_t  in_pkt,
    input  logic      in_valid,
    output logic      in_ready,
    output dbus_req_t dbus_req,
    output logic      dbus_req_valid,
    input  logic      dbus_req_ready,
    input  logic      dbus_rsp_valid,
    input  word_t     dbus_rsp_data,
    output wb_pkt_t   out_pkt,
    output logic      out_valid,
    input  logic      out_ready
);
    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT,
        S_OUT
    } state_t;

    state_t    state;
    dbus_req_t req_q;
    wb_pkt_t   wb_q;
    logic      accept;

    assign in_ready = (state == S_IDLE);
    assign accept = in_valid && in_ready;
    assign dbus_req = req_q;
    assign dbus_req_valid = (state == S_REQ);
    assign out_pkt = wb_q;
    assign out_valid = (state == S_OUT);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (accept) begin
                    state <= (in_pkt.is_load || in_pkt.is_store) ? S_REQ : S_OUT;
                end
                S_REQ:  if (dbus_req_ready) state <= S_WAIT;
                S_WAIT: if (dbus_rsp_valid) state <= S_OUT;
                S_OUT:  if (out_ready) state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q.addr <= in_pkt.result;
            req_q.write <= in_pkt.is_store;
            req_q.wdata <= in_pkt.store_data;
            wb_q.rd <= in_pkt.rd;
            wb_q.rd_we <= in_pkt.rd_we;
            wb_q.result <= in_pkt.result;
            wb_q.next_pc <= in_pkt.next_pc;
            wb_q.is_halt <= in_pkt.is_halt;
        end else if (state == S_WAIT && dbus_rsp_valid && !req_q.write) begin
            wb_q.result <= dbus_rsp_data;   // load data replaces the address
        end
    end
endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
    import core_pkg::*;
    import isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  exec_pkt_t in_pkt,
    input  logic      in_valid,
    output logic      in_ready,
    output mem_pkt_t  out_pkt,
    output logic      out_valid,
    input  logic      out_ready
);
    word_t    result;
    word_t    target;
    logic     taken;
    mem_pkt_t pkt;

    always_comb begin
        case (in_pkt.alu_op)
            ALU_ADD: result = in_pkt.op_a + in_pkt.op_b;
            ALU_SUB: result = in_pkt.op_a - in_pkt.op_b;
            ALU_AND: result = in_pkt.op_a & in_pkt.op_b;
            ALU_OR:  result = in_pkt.op_a | in_pkt.op_b;
            ALU_XOR: result = in_pkt.op_a ^ in_pkt.op_b;
            ALU_SLT: result = word_t'($signed(in_pkt.op_a) < $signed(in_pkt.op_b));
            default: result = in_pkt.op_a + in_pkt.op_b;
        endcase
    end

    // operands carry rs1 and rs2 for branches
    assign taken = in_pkt.is_branch && ((in_pkt.op_a == in_pkt.op_b) != in_pkt.branch_ne);
    assign target = in_pkt.pc + in_pkt.imm;

    always_comb begin
        pkt.rd = in_pkt.rd;
        pkt.rd_we = in_pkt.rd_we;
        pkt.result = result;
        pkt.is_load = in_pkt.is_load;
        pkt.is_store = in_pkt.is_store;
        pkt.store_data = in_pkt.store_data;
        pkt.next_pc = (taken || in_pkt.is_jal) ? target : in_pkt.pc + word_t'(4);
        pkt.is_halt = in_pkt.is_halt;
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_pkt <= pkt;
        end
    end
endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
    import core_pkg::*;
    import isa_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  fetch_pkt_t in_pkt,
    input  logic       in_valid,
    output logic       in_ready,
    output reg_addr_t  rs1,
    output reg_addr_t  rs2,
    input  word_t      rs1_data,
    input  word_t      rs2_data,
    output exec_pkt_t  out_pkt,
    output logic       out_valid,
    input  logic       out_ready
);
    instr_t    instr;
    word_t     imm_i;
    word_t     imm_s;
    word_t     imm_b;
    word_t     imm_u;
    word_t     imm_j;
    exec_pkt_t pkt;

    function automatic alu_op_t alu_from_funct(logic [2:0] funct3, logic is_sub);
        case (funct3)
            F3_ADD:  return is_sub ? ALU_SUB : ALU_ADD;
            F3_SLT:  return ALU_SLT;
            F3_XOR:  return ALU_XOR;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign instr = in_pkt.instr;
    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;

    assign imm_i = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
    assign imm_s = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
    assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                    instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
    assign imm_u = {instr.u.imm_31_12, 12'b0};
    assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                    instr.j.imm_11, instr.j.imm_10_1, 1'b0};

    always_comb begin
        pkt = '0;
        pkt.pc = in_pkt.pc;
        pkt.alu_op = ALU_ADD;
        pkt.op_a = rs1_data;
        pkt.op_b = rs2_data;
        pkt.store_data = rs2_data;
        pkt.rd = instr.r.rd;
        case (instr.r.opcode)
            OPC_OP: begin
                pkt.alu_op = alu_from_funct(instr.r.funct3, instr.r.funct7 == FUNCT7_SUB);
                pkt.rd_we = 1'b1;
            end
            OPC_OP_IMM: begin
                pkt.alu_op = alu_from_funct(instr.i.funct3, 1'b0);
                pkt.op_b = imm_i;
                pkt.rd_we = 1'b1;
            end
            OPC_LUI: begin
                pkt.op_a = '0;
                pkt.op_b = imm_u;
                pkt.rd_we = 1'b1;
            end
            OPC_LOAD: begin
                pkt.op_b = imm_i;
                pkt.rd_we = 1'b1;
                pkt.is_load = 1'b1;
            end
            OPC_STORE: begin
                pkt.op_b = imm_s;
                pkt.is_store = 1'b1;
            end
            OPC_BRANCH: begin
                pkt.imm = imm_b;
                case (instr.b.funct3)
                    F3_BEQ:  pkt.is_branch = 1'b1;
                    F3_BNE: begin
                        pkt.is_branch = 1'b1;
                        pkt.branch_ne = 1'b1;
                    end
                    default: pkt.is_branch = 1'b0;   // other compares fall through
                endcase
            end
            OPC_JAL: begin
                pkt.op_a = in_pkt.pc;   // link value is pc + 4
                pkt.op_b = word_t'(4);
                pkt.rd_we = 1'b1;
                pkt.is_jal = 1'b1;
                pkt.imm = imm_j;
            end
            OPC_SYSTEM: pkt.is_halt = 1'b1;
            default: ;   // no-op
        endcase
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_pkt <= pkt;
        end
    end
endmodule

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    output ibus_req_t  ibus_req,
    output logic       ibus_req_valid,
    input  logic       ibus_req_ready,
    input  logic       ibus_rsp_valid,
    input  word_t      ibus_rsp_data,
    input  logic       pc_valid,
    input  word_t      next_pc,
    input  logic       halt,
    output fetch_pkt_t out_pkt,
    output logic       out_valid,
    input  logic       out_ready,
    output logic       halted
);
    word_t pc;
    logic  token;     // a pc is queued and not yet requested
    logic  started;

    assign ibus_req_valid = token;
    assign ibus_req.addr = pc;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= RESET_PC;
            token <= 1'b0;
            started <= 1'b0;
            halted <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (!started) begin
                started <= 1'b1;
                token <= 1'b1;   // first fetch right after reset
            end else if (ibus_req_valid && ibus_req_ready) begin
                token <= 1'b0;
            end
            if (ibus_rsp_valid) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
            if (pc_valid) begin
                pc <= next_pc;
                if (halt) begin
                    halted <= 1'b1;
                end else begin
                    token <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ibus_rsp_valid) begin
            out_pkt.pc <= pc;
            out_pkt.instr <= ibus_rsp_data;
        end
    end
endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps

module register_file
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  reg_addr_t rd,
    input  word_t     rd_data,
    input  logic      rd_we
);
    word_t regs [2**REG_ADDR_W];

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end
endmodule

// ==== rtl/core_pkg.sv ====
package core_pkg;
    import isa_pkg::*;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam logic [XLEN-1:0] RESET_PC = '0;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_pkt_t;

    typedef struct packed {
        word_t     pc;
        alu_op_t   alu_op;
        word_t     op_a;
        word_t     op_b;
        word_t     store_data;
        reg_addr_t rd;
        logic      rd_we;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
        logic      branch_ne;   // bne when set, beq otherwise
        logic      is_jal;
        word_t     imm;         // branch or jump offset
        logic      is_halt;
    } exec_pkt_t;

    typedef struct packed {
        reg_addr_t rd;
        logic      rd_we;
        word_t     result;      // address for lw and sw
        logic      is_load;
        logic      is_store;
        word_t     store_data;
        word_t     next_pc;
        logic      is_halt;
    } mem_pkt_t;

    typedef struct packed {
        reg_addr_t rd;
        logic      rd_we;
        word_t     result;
        word_t     next_pc;
        logic      is_halt;
    } wb_pkt_t;

    typedef struct packed {
        word_t addr;
    } ibus_req_t;

    typedef struct packed {
        word_t addr;
        logic  write;
        word_t wdata;
    } dbus_req_t;

endpackage

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011   // only ecall is recognised
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

    localparam logic [4:0] X0 = 5'd0;   // hardwired zero register

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // one instruction word viewed per format
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_t;

endpackage
